// ==== compile.f ====
common/memMapPkg.sv
verilog/memMapDecode.sv
verilog/dataRam.sv
io/ioBlock.sv
verilog/videoRam.sv
verilog/readReturn.sv
verilog/memMapTop.sv
dv/memMapTb.sv

// ==== Makefile ====
# Verilator simulation of the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= memMapTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/memMapTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module memMapTb import memMapPkg::*; ();

    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_IDLE    = 2;
    localparam int FLAG_LIMIT = 64;     // Cycles allowed for each flag to rise

    logic clk;
    logic arstN;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] writeData;
    logic writeEn;
    logic readEn;
    logic topFlagClr;
    logic match0FlagClr;
    logic match1FlagClr;
    logic [DATA_W-1:0] readData;
    logic [DATA_W-1:0] ioPins;
    logic topFlag;
    logic match0Flag;
    logic match1Flag;

    int seed;
    int testCount;
    int checkCount;
    int errorCount;
    int testErrors;

    // Stimulus table with one row per bus cycle
    int opQ[$];
    logic [ADDR_W-1:0] addrQ[$];
    logic [DATA_W-1:0] dataQ[$];
    logic [DATA_W-1:0] expQ[$];

    memMapTop dut_i (
        .clk           (clk),
        .arstN         (arstN),
        .address       (address),
        .writeData     (writeData),
        .writeEn       (writeEn),
        .readEn        (readEn),
        .topFlagClr    (topFlagClr),
        .match0FlagClr (match0FlagClr),
        .match1FlagClr (match1FlagClr),
        .readData      (readData),
        .ioPins        (ioPins),
        .topFlag       (topFlag),
        .match0Flag    (match0Flag),
        .match1Flag    (match1Flag)
    );

    always #20 clk = ~clk;

    //******************************
    // Helpers
    function automatic logic [ADDR_W-1:0] ioAddr(input logic [7:0] offset);
        return {IO_BASE[ADDR_W-1:8], offset};      // Offset is the low byte
    endfunction

    function automatic logic [DATA_W-1:0] nextByte();
        int r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    task automatic checkByte(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic checkFlags(input logic [2:0] expected, input logic [2:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("Fail flags {match1,match0,top}: expected 0x%h, got 0x%h",
                     expected, actual);
        end
    endtask

    task automatic addWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        opQ.push_back(OP_WRITE);
        addrQ.push_back(addr);
        dataQ.push_back(data);
        expQ.push_back(8'h00);
    endtask

    task automatic addRead(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
        opQ.push_back(OP_READ);
        addrQ.push_back(addr);
        dataQ.push_back(8'h00);
        expQ.push_back(expected);
    endtask

    // Applies the table and checks each read one cycle after its strobe
    task automatic runTable();
        int rows;
        int stageOp [2];
        logic [ADDR_W-1:0] stageAddr [2];
        logic [DATA_W-1:0] stageExp [2];
        rows = opQ.size();
        for (int s = 0; s < 2; s++) begin
            stageOp[s] = OP_IDLE;
        end
        for (int i = 0; i < rows + 1; i++) begin
            @(posedge clk);
            stageOp[1]   = stageOp[0];
            stageAddr[1] = stageAddr[0];
            stageExp[1]  = stageExp[0];
            if (i < rows) begin
                address   <= addrQ[i];
                writeData <= dataQ[i];
                writeEn   <= (opQ[i] == OP_WRITE);
                readEn    <= (opQ[i] == OP_READ);
                stageOp[0]   = opQ[i];
                stageAddr[0] = addrQ[i];
                stageExp[0]  = expQ[i];
            end
            else begin
                writeEn <= 1'b0;
                readEn  <= 1'b0;
                stageOp[0] = OP_IDLE;         // Flush cycle
            end
            @(negedge clk);
            if (stageOp[1] == OP_READ) begin
                checkByte($sformatf("readData at 0x%h", stageAddr[1]), stageExp[1], readData);
            end
        end
        opQ.delete();
        addrQ.delete();
        dataQ.delete();
        expQ.delete();
    endtask

    task automatic waitFlag(input int which, input string name);
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < FLAG_LIMIT) begin
            @(negedge clk);
            cycles++;
            case (which)
                0:       seen = topFlag;
                1:       seen = match0Flag;
                default: seen = match1Flag;
            endcase
        end
        if (!seen) begin
            errorCount++;
            testErrors++;
            $display("Timeout: %s did not rise within %0d cycles", name, FLAG_LIMIT);
        end
    endtask

    task automatic pulseClear(input int which);
        @(posedge clk);
        topFlagClr    <= (which == 0);
        match0FlagClr <= (which == 1);
        match1FlagClr <= (which == 2);
        @(posedge clk);
        topFlagClr    <= 1'b0;
        match0FlagClr <= 1'b0;
        match1FlagClr <= 1'b0;
        @(negedge clk);
    endtask

    task automatic startTest();
        testCount++;
        testErrors = 0;
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("Test %0d %s: pass", testCount, name);
        end
        else begin
            $display("Test %0d %s: %0d failed checks", testCount, name, testErrors);
        end
    endtask

    //******************************
    // Test sequence
    initial begin
        logic [DATA_W-1:0] d0;
        logic [DATA_W-1:0] d1;
        logic [DATA_W-1:0] d2;
        logic [DATA_W-1:0] v0;
        logic [DATA_W-1:0] v1;
        logic [DATA_W-1:0] pins;

        seed = 32'h1c04_e4d2;
        testCount = 0;
        checkCount = 0;
        errorCount = 0;
        clk = 1'b0;
        arstN = 1'b0;
        address = '0;
        writeData = '0;
        writeEn = 1'b0;
        readEn = 1'b0;
        topFlagClr = 1'b0;
        match0FlagClr = 1'b0;
        match1FlagClr = 1'b0;

        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);

        startTest();
        checkByte("ioPins", 8'h00, ioPins);
        checkByte("readData", 8'h00, readData);
        checkFlags(3'b000, {match1Flag, match0Flag, topFlag});
        addRead(ioAddr(REG_TCOUNT), 8'h00);
        runTable();
        finishTest("reset state");

        startTest();
        d0 = nextByte();
        d1 = nextByte();
        d2 = nextByte();
        addWrite(16'h0000, d0);
        addWrite(16'h0123, d1);
        addWrite(16'h07FF, d2);
        addRead(16'h0000, d0);
        addRead(16'h0123, d1);
        addRead(16'h07FF, d2);
        addRead(16'h0000, d0);                  // Back to back across regions
        addRead(ioAddr(REG_TTOP), 8'hFF);
        addRead(16'h07FF, d2);
        addRead(16'h0800, 8'h00);
        addRead(16'h0123, d1);
        runTable();
        finishTest("data RAM");

        startTest();
        v0 = nextByte();
        v1 = nextByte();
        addWrite(16'h2000, v0);
        addWrite(16'h2960, v1);
        addRead(16'h2000, v0);
        addRead(16'h2960, v1);
        addRead(16'h0800, 8'h00);
        addRead(16'h1FFF, 8'h00);
        addRead(16'h2961, 8'h00);
        addWrite(16'h0800, ~d0);                // Unmapped write must not alias
        addRead(16'h0000, d0);
        addRead(16'h2000, v0);
        addRead(16'h0123, d1);
        addRead(16'h2960, v1);
        runTable();
        finishTest("video RAM and unmapped");

        startTest();
        pins = nextByte();
        addWrite(ioAddr(REG_PINS), pins);
        addRead(ioAddr(REG_PINS), pins);
        runTable();
        checkByte("ioPins", pins, ioPins);
        finishTest("pin register");

        startTest();
        addWrite(ioAddr(REG_TTOP), 8'd9);
        addWrite(ioAddr(REG_TMATCH0), 8'd3);
        addWrite(ioAddr(REG_TMATCH1), 8'd7);
        addWrite(ioAddr(REG_TCTRL), 8'h01);
        addRead(ioAddr(REG_TTOP), 8'd9);
        runTable();
        waitFlag(0, "topFlag");
        waitFlag(1, "match0Flag");
        waitFlag(2, "match1Flag");
        addRead(ioAddr(REG_FLAGS), 8'h07);
        runTable();
        finishTest("timer flags");

        startTest();
        addWrite(ioAddr(REG_TCTRL), 8'h00);     // Stop the timer first
        addRead(ioAddr(REG_TCTRL), 8'h00);
        runTable();
        checkFlags(3'b111, {match1Flag, match0Flag, topFlag});
        pulseClear(0);
        checkFlags(3'b110, {match1Flag, match0Flag, topFlag});
        pulseClear(1);
        checkFlags(3'b100, {match1Flag, match0Flag, topFlag});
        pulseClear(2);
        checkFlags(3'b000, {match1Flag, match0Flag, topFlag});
        repeat (20) @(posedge clk);
        @(negedge clk);
        checkFlags(3'b000, {match1Flag, match0Flag, topFlag});
        addRead(ioAddr(REG_FLAGS), 8'h00);
        runTable();
        finishTest("flag clear");

        $display("Tests: %0d, checks: %0d, failed checks: %0d",
                 testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/memMapTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module memMapTop import memMapPkg::*; (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic [ADDR_W-1:0]   address,
    input  wire logic [DATA_W-1:0]   writeData,
    input  wire logic                writeEn,
    input  wire logic                readEn,
    input  wire logic                topFlagClr,
    input  wire logic                match0FlagClr,
    input  wire logic                match1FlagClr,
    output logic [DATA_W-1:0]        readData,
    output logic [DATA_W-1:0]        ioPins,
    output logic                     topFlag,
    output logic                     match0Flag,
    output logic                     match1Flag
);

    //******************************
    // Decode
    logic dataWriteEn;
    logic dataReadEn;
    logic ioWriteEn;
    logic ioReadEn;
    logic vidWriteEn;
    logic vidReadEn;
    logic [REGION_W-1:0] readRegion;

    memMapDecode decode_i (
        .address     (address),
        .writeEn     (writeEn),
        .readEn      (readEn),
        .dataWriteEn (dataWriteEn),
        .dataReadEn  (dataReadEn),
        .ioWriteEn   (ioWriteEn),
        .ioReadEn    (ioReadEn),
        .vidWriteEn  (vidWriteEn),
        .vidReadEn   (vidReadEn),
        .readRegion  (readRegion)
    );

    //******************************
    // Targets
    logic [DATA_W-1:0] dataReadData;
    logic [DATA_W-1:0] ioReadData;
    logic [DATA_W-1:0] vidReadData;

    dataRam dataRam_i (
        .clk       (clk),
        .arstN     (arstN),
        .address   (address),
        .writeData (writeData),
        .writeEn   (dataWriteEn),
        .readEn    (dataReadEn),
        .readData  (dataReadData)
    );

    ioBlock ioBlock_i (
        .clk           (clk),
        .arstN         (arstN),
        .address       (address),
        .writeData     (writeData),
        .writeEn       (ioWriteEn),
        .readEn        (ioReadEn),
        .topFlagClr    (topFlagClr),
        .match0FlagClr (match0FlagClr),
        .match1FlagClr (match1FlagClr),
        .readData      (ioReadData),
        .ioPins        (ioPins),
        .topFlag       (topFlag),
        .match0Flag    (match0Flag),
        .match1Flag    (match1Flag)
    );

    videoRam videoRam_i (
        .clk       (clk),
        .arstN     (arstN),
        .address   (address),
        .writeData (writeData),
        .writeEn   (vidWriteEn),
        .readEn    (vidReadEn),
        .readData  (vidReadData)
    );

    //******************************
    // Read return
    readReturn readReturn_i (
        .clk          (clk),
        .arstN        (arstN),
        .readEn       (readEn),
        .readRegion   (readRegion),
        .dataReadData (dataReadData),
        .ioReadData   (ioReadData),
        .vidReadData  (vidReadData),
        .readData     (readData)
    );

endmodule

`default_nettype wire

// ==== verilog/readReturn.sv ====
`timescale 1ns/10ps
`default_nettype none

module readReturn import memMapPkg::*; (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                readEn,
    input  wire logic [REGION_W-1:0] readRegion,
    input  wire logic [DATA_W-1:0]   dataReadData,
    input  wire logic [DATA_W-1:0]   ioReadData,
    input  wire logic [DATA_W-1:0]   vidReadData,
    output logic [DATA_W-1:0]        readData
);

    logic [REGION_W-1:0] regionQ;

    // Region of the read in flight, NONE when no strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regionQ <= REGION_NONE;
        end
        else begin
            regionQ <= readEn ? readRegion : REGION_NONE;
        end
    end

    // Lines up with the one-cycle target read
    always_comb begin
        case (regionQ)
            REGION_DATA: readData = dataReadData;
            REGION_IO:   readData = ioReadData;
            REGION_VID:  readData = vidReadData;
            default:     readData = '0;          // Unmapped or idle
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/videoRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module videoRam import memMapPkg::*; (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic [ADDR_W-1:0]   address,
    input  wire logic [DATA_W-1:0]   writeData,
    input  wire logic                writeEn,
    input  wire logic                readEn,
    output logic [DATA_W-1:0]        readData
);

    // Text screen characters, scanned by an external display engine
    logic [DATA_W-1:0] mem [VID_DEPTH];
    logic [ADDR_W-1:0] offset;
    logic [VID_IDX_W-1:0] index;

    assign offset = address - VID_BASE;
    assign index  = offset[VID_IDX_W-1:0];      // Upper bits zero inside the range

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[index] <= writeData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end
        else if (readEn) begin
            readData <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== io/ioBlock.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioBlock import memMapPkg::*; (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic [ADDR_W-1:0]   address,
    input  wire logic [DATA_W-1:0]   writeData,
    input  wire logic                writeEn,
    input  wire logic                readEn,
    input  wire logic                topFlagClr,
    input  wire logic                match0FlagClr,
    input  wire logic                match1FlagClr,
    output logic [DATA_W-1:0]        readData,
    output logic [DATA_W-1:0]        ioPins,
    output logic                     topFlag,
    output logic                     match0Flag,
    output logic                     match1Flag
);

    logic [7:0] offset;
    logic       timerEn;
    logic [DATA_W-1:0] timerTop;
    logic [DATA_W-1:0] timerMatch0;
    logic [DATA_W-1:0] timerMatch1;
    logic [DATA_W-1:0] timerCount;
    logic [2:0] flagSet;
    logic [2:0] flagClr;
    logic [2:0] flags;                  // {match1, match0, top}

    assign offset = address[7:0];

    //******************************
    // Register writes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ioPins      <= '0;
            timerEn     <= 1'b0;
            timerTop    <= 8'hFF;
            timerMatch0 <= 8'hFF;
            timerMatch1 <= 8'hFF;
        end
        else if (writeEn) begin
            case (offset)
                REG_PINS:    ioPins      <= writeData;
                REG_TCTRL:   timerEn     <= writeData[0];
                REG_TTOP:    timerTop    <= writeData;
                REG_TMATCH0: timerMatch0 <= writeData;
                REG_TMATCH1: timerMatch1 <= writeData;
                default: ;                                  // Read-only or unused
            endcase
        end
    end

    //******************************
    // Timer, wraps to 0 after top
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timerCount <= '0;
        end
        else if (timerEn) begin
            if (timerCount == timerTop) begin
                timerCount <= '0;
            end
            else begin
                timerCount <= timerCount + 8'd1;
            end
        end
    end

    assign flagSet[0] = timerEn && (timerCount == timerTop);
    assign flagSet[1] = timerEn && (timerCount == timerMatch0);
    assign flagSet[2] = timerEn && (timerCount == timerMatch1);
    assign flagClr    = {match1FlagClr, match0FlagClr, topFlagClr};

    // Sticky flags, set beats clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end
        else begin
            for (int i = 0; i < 3; i++) begin
                if (flagSet[i]) begin
                    flags[i] <= 1'b1;
                end
                else if (flagClr[i]) begin
                    flags[i] <= 1'b0;
                end
            end
        end
    end

    assign topFlag    = flags[0];
    assign match0Flag = flags[1];
    assign match1Flag = flags[2];

    //******************************
    // Registered read
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end
        else if (readEn) begin
            case (offset)
                REG_PINS:    readData <= ioPins;
                REG_TCTRL:   readData <= {7'd0, timerEn};
                REG_TTOP:    readData <= timerTop;
                REG_TMATCH0: readData <= timerMatch0;
                REG_TMATCH1: readData <= timerMatch1;
                REG_FLAGS:   readData <= {5'd0, flags};
                REG_TCOUNT:  readData <= timerCount;
                default:     readData <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataRam import memMapPkg::*; (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic [ADDR_W-1:0]   address,
    input  wire logic [DATA_W-1:0]   writeData,
    input  wire logic                writeEn,
    input  wire logic                readEn,
    output logic [DATA_W-1:0]        readData
);

    logic [DATA_W-1:0] mem [DATA_DEPTH];
    logic [DATA_IDX_W-1:0] index;

    assign index = address[DATA_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[index] <= writeData;
        end
    end

    // Registered read, holds between strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end
        else if (readEn) begin
            readData <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memMapDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module memMapDecode import memMapPkg::*; (
    input  wire logic [ADDR_W-1:0]   address,
    input  wire logic                writeEn,
    input  wire logic                readEn,
    output logic                     dataWriteEn,
    output logic                     dataReadEn,
    output logic                     ioWriteEn,
    output logic                     ioReadEn,
    output logic                     vidWriteEn,
    output logic                     vidReadEn,
    output logic [REGION_W-1:0]      readRegion
);

    // One priority chain, first matching range wins
    always_comb begin
        dataWriteEn = 1'b0;
        dataReadEn  = 1'b0;
        ioWriteEn   = 1'b0;
        ioReadEn    = 1'b0;
        vidWriteEn  = 1'b0;
        vidReadEn   = 1'b0;
        readRegion  = REGION_NONE;

        if (address >= DATA_BASE && address <= DATA_LAST) begin          // Data RAM
            dataWriteEn = writeEn;
            dataReadEn  = readEn;
            readRegion  = REGION_DATA;
        end
        else if (address >= IO_BASE && address <= IO_LAST) begin         // I/O
            ioWriteEn  = writeEn;
            ioReadEn   = readEn;
            readRegion = REGION_IO;
        end
        else if (address >= VID_BASE && address <= VID_LAST) begin       // Video RAM
            vidWriteEn = writeEn;
            vidReadEn  = readEn;
            readRegion = REGION_VID;
        end
        // Unmapped falls through with no strobes
    end

endmodule

`default_nettype wire

// ==== common/memMapPkg.sv ====
`default_nettype none

package memMapPkg;

    //******************************
    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    //******************************
    // Address map
    localparam logic [ADDR_W-1:0] DATA_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] DATA_LAST = 16'h07FF;
    localparam int DATA_DEPTH = 2048;
    localparam int DATA_IDX_W = 11;     // Low address bits into data RAM

    localparam logic [ADDR_W-1:0] IO_BASE = 16'h1000;
    localparam logic [ADDR_W-1:0] IO_LAST = 16'h10FF;

    localparam logic [ADDR_W-1:0] VID_BASE = 16'h2000;
    localparam logic [ADDR_W-1:0] VID_LAST = 16'h2960;
    localparam int VID_DEPTH = 2401;
    localparam int VID_IDX_W = 12;      // Enough for 0..2400

    //******************************
    // I/O register offsets, low address byte
    localparam logic [7:0] REG_PINS    = 8'h00;
    localparam logic [7:0] REG_TCTRL   = 8'h01;   // Bit 0 enables the timer
    localparam logic [7:0] REG_TTOP    = 8'h02;
    localparam logic [7:0] REG_TMATCH0 = 8'h03;
    localparam logic [7:0] REG_TMATCH1 = 8'h04;
    localparam logic [7:0] REG_FLAGS   = 8'h05;   // Read only, {match1, match0, top}
    localparam logic [7:0] REG_TCOUNT  = 8'h06;   // Read only

    //******************************
    // Region codes, decode to read return
    localparam int REGION_W = 2;
    localparam logic [REGION_W-1:0] REGION_NONE = 2'd0;
    localparam logic [REGION_W-1:0] REGION_DATA = 2'd1;
    localparam logic [REGION_W-1:0] REGION_IO   = 2'd2;
    localparam logic [REGION_W-1:0] REGION_VID  = 2'd3;

endpackage

`default_nettype wire
